//--- common/video_pkg.sv
// video side definitions for the colour mixer
// layer pixel formats, palette geometry, output colour and blank delay

package video_pkg;

    localparam int gfx_layers = 4;      // char, scr1, scr2, obj

    // layer pixel widths, priority bits on top
    localparam int char_w = 7;          // 6 colour bits + tile priority
    localparam int scr_w  = 11;         // 10 colour bits + tile priority
    localparam int obj_w  = 12;         // 10 colour bits + 2 priority bits

    // palette
    localparam int pal_aw   = 11;       // msb selects object half
    localparam int char_pad = pal_aw - char_w;  // zero bits above char colour
    localparam int rgb_w    = 15;       // packed colour in palette word
    localparam int col_w    = 5;        // per channel out

    // pxl_cen stages between palette and pins
    localparam int blank_dly = 2;

    // slot that won the opaque search
    typedef enum logic [1:0] {
        LYR_CHAR = 2'd0,
        LYR_SCR1 = 2'd1,
        LYR_SCR2 = 2'd2
    } lyr_src_e;

endpackage

//--- common/cpu_pkg.sv
// cpu side definitions for the palette port
// word address, data width and byte lane enables

package cpu_pkg;

    localparam int cpu_aw     = 11;     // word address
    localparam int cpu_dw     = 16;
    localparam int cpu_bw     = 8;      // one lane
    localparam int cpu_nbytes = cpu_dw / cpu_bw;

    // active high, bit 0 is the low byte
    typedef logic [cpu_nbytes-1:0] byte_en_t;

endpackage

//--- common/pix_if.sv
// pixel path bundle inside the colour mixer
// palette address from the resolver plus the pixel strobe and
// blanking levels shared by palette and blank stage

`timescale 1ns/100ps

interface pix_if import video_pkg::*; ();

    logic [pal_aw-1:0] pal_addr;    // resolved palette index
    logic              pxl_cen;     // pixel clock enable
    logic              lhbl;        // low during hblank
    logic              lvbl;        // low during vblank

    // resolver side
    modport src (
        output pal_addr,
        input  pxl_cen
    );

    // palette ram and blank stage
    modport snk (
        input pal_addr,
        input pxl_cen,
        input lhbl,
        input lvbl
    );

endinterface

//--- colmix/colmix_prio.sv
// layer priority resolver
// gates debug-disabled layers, settles tile against object in each of
// the three slots on pxl_cen, then takes the first opaque slot
// (char, scr1, scr2) as the palette address

`timescale 1ns/100ps

module colmix_prio import video_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [gfx_layers-1:0] gfx_en,
    input  logic [char_w-1:0]     char_pxl,
    input  logic [scr_w-1:0]      scr1_pxl,
    input  logic [scr_w-1:0]      scr2_pxl,
    input  logic [obj_w-1:0]      obj_pxl,
    pix_if.src                    pix
);

    logic [char_w-1:0] char_g;
    logic [scr_w-1:0]  scr1_g, scr2_g;
    logic [obj_w-1:0]  obj_g;
    logic [1:0]        obj_prio;
    logic [pal_aw-1:0] lyr0, lyr1, lyr2;    // char, scr1, scr2 slots
    lyr_src_e          win;

    // object takes the slot only if visible, allowed and tile not on top
    function automatic logic [pal_aw-1:0] tile_or_obj(
        input logic [pal_aw-2:0] obj,
        input logic [pal_aw-2:0] tile,
        input logic              tile_prio,
        input logic              obj_ok
    );
        if (obj[3:0] != 4'd0 && obj_ok && !tile_prio)
            tile_or_obj = {1'b1, obj};
        else
            tile_or_obj = {1'b0, tile};
    endfunction

    // objects count 4 colour bits, tiles only 3
    function automatic logic opaque(input logic [pal_aw-1:0] v);
        opaque = v[pal_aw-1] ? (v[3:0] != 4'd0) : (v[2:0] != 3'd0);
    endfunction

    // debug gating, colour index only, priority bits survive
    always_comb begin
        char_g = char_pxl;
        scr1_g = scr1_pxl;
        scr2_g = scr2_pxl;
        obj_g  = obj_pxl;
        if (!gfx_en[0]) char_g[3:0] = 4'd0;
        if (!gfx_en[1]) scr1_g[3:0] = 4'd0;
        if (!gfx_en[2]) scr2_g[3:0] = 4'd0;
        if (!gfx_en[3]) obj_g[3:0]  = 4'd0;
    end

    assign obj_prio = obj_g[obj_w-1 -: 2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lyr0 <= '0;
            lyr1 <= '0;
            lyr2 <= '0;
        end else if (pix.pxl_cen) begin
            // char tile colour zero-extended to the slot width
            lyr0 <= tile_or_obj(obj_g[pal_aw-2:0], {{char_pad{1'b0}}, char_g[char_w-2:0]},
                                char_g[char_w-1], obj_prio == 2'd3);
            lyr1 <= tile_or_obj(obj_g[pal_aw-2:0], scr1_g[scr_w-2:0],
                                scr1_g[scr_w-1], obj_prio >= 2'd2);
            lyr2 <= tile_or_obj(obj_g[pal_aw-2:0], scr2_g[scr_w-2:0],
                                scr2_g[scr_w-1], obj_prio >= 2'd1);
        end
    end

    always_comb begin
        if (opaque(lyr0))      win = LYR_CHAR;
        else if (opaque(lyr1)) win = LYR_SCR1;
        else                   win = LYR_SCR2;    // backdrop, even if clear
    end

    always_comb begin
        case (win)
            LYR_CHAR: pix.pal_addr = lyr0;
            LYR_SCR1: pix.pal_addr = lyr1;
            default:  pix.pal_addr = lyr2;
        endcase
    end

    // object half of the palette only after a visible object was sampled
    a_obj_visible: assert property (@(posedge clk) disable iff (!rst_n)
        (pix.pxl_cen ##1 pix.pal_addr[pal_aw-1]) |-> ($past(obj_g[3:0]) != 4'd0));

endmodule

//--- colmix/colmix_palram.sv
// palette ram, 2K x 16 true dual port
// cpu port: byte lane writes and registered read-back
// video port: registered read at the resolved palette address

`timescale 1ns/100ps

module colmix_palram
    import video_pkg::*;
    import cpu_pkg::*;
(
    input  logic              clk,
    input  logic [cpu_aw-1:0] cpu_addr,
    input  logic [cpu_dw-1:0] cpu_dout,
    input  byte_en_t          we,
    output logic [cpu_dw-1:0] cpu_din,
    pix_if.snk                pix,
    output logic [rgb_w:0]    pal
);

    logic [cpu_dw-1:0] mem [2**pal_aw];     // no reset, contents kept

    // cpu side, read returns old word on a write cycle
    always_ff @(posedge clk) begin
        for (int b = 0; b < cpu_nbytes; b++) begin
            if (we[b])
                mem[cpu_addr][b*cpu_bw +: cpu_bw] <= cpu_dout[b*cpu_bw +: cpu_bw];
        end
        cpu_din <= mem[cpu_addr];
    end

    // video side, one clk after pal_addr
    always_ff @(posedge clk) begin
        pal <= mem[pix.pal_addr];
    end

    // a write to an unknown address would smear the palette
    a_we_addr_known: assert property (@(posedge clk)
        (we != '0) |-> !$isunknown(cpu_addr));

endmodule

//--- colmix/colmix_blank.sv
// blanking and rgb output stage
// video_en gating, blank_dly pxl_cen delay line for colour and the
// blanking levels, colour forced to zero while blanked, then the
// palette bits are spread over three 5-bit channels

`timescale 1ns/100ps

module colmix_blank import video_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             video_en,
    input  logic [rgb_w:0]   pal,          // top bit carries no colour
    pix_if.snk               pix,
    output logic [col_w-1:0] red,
    output logic [col_w-1:0] green,
    output logic [col_w-1:0] blue,
    output logic             lhbl_dly,
    output logic             lvbl_dly
);

    logic [rgb_w-1:0]                 col_gated;
    logic [blank_dly-1:0][rgb_w-1:0]  col_sr;   // [0] newest
    logic [blank_dly-1:0]             hbl_sr, vbl_sr;
    logic [rgb_w-1:0]                 col;

    assign col_gated = video_en ? pal[rgb_w-1:0] : '0;   // debug video off

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_sr <= '0;
            hbl_sr <= '0;
            vbl_sr <= '0;
        end else if (pix.pxl_cen) begin
            // blank at the input so colour and strobes stay in step
            col_sr <= {col_sr[blank_dly-2:0], (pix.lhbl && pix.lvbl) ? col_gated : '0};
            hbl_sr <= {hbl_sr[blank_dly-2:0], pix.lhbl};
            vbl_sr <= {vbl_sr[blank_dly-2:0], pix.lvbl};
        end
    end

    assign col      = col_sr[blank_dly-1];
    assign lhbl_dly = hbl_sr[blank_dly-1];
    assign lvbl_dly = vbl_sr[blank_dly-1];

    // 4 msbs per channel plus one shared low bit each
    assign red   = {col[3:0],  col[12]};
    assign green = {col[7:4],  col[13]};
    assign blue  = {col[11:8], col[14]};

    // black on the pins for the whole delayed hblank
    a_black_in_hblank: assert property (@(posedge clk) disable iff (!rst_n)
        !lhbl_dly |-> (red == '0 && green == '0 && blue == '0));

endmodule

//--- verilog/colmix_top.sv
// colour mixer top level
// layer priority resolver -> palette ram -> blank/rgb stage
// cpu gets byte-wise palette access through a level chip select

`timescale 1ns/100ps

module colmix_top
    import video_pkg::*;
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pxl_cen,
    input  logic                  video_en,
    input  logic [gfx_layers-1:0] gfx_en,
    input  logic                  lhbl,
    input  logic                  lvbl,
    input  logic                  pal_cs,
    input  logic [cpu_aw-1:0]     cpu_addr,
    input  logic [cpu_dw-1:0]     cpu_dout,
    input  logic [cpu_nbytes-1:0] dsn,          // active low lanes
    input  logic [char_w-1:0]     char_pxl,
    input  logic [scr_w-1:0]      scr1_pxl,
    input  logic [scr_w-1:0]      scr2_pxl,
    input  logic [obj_w-1:0]      obj_pxl,
    output logic [cpu_dw-1:0]     cpu_din,
    output logic [col_w-1:0]      red,
    output logic [col_w-1:0]      green,
    output logic [col_w-1:0]      blue,
    output logic                  lhbl_dly,
    output logic                  lvbl_dly
);

    byte_en_t       we;
    logic [rgb_w:0] pal;

    pix_if pix ();

    assign pix.pxl_cen = pxl_cen;
    assign pix.lhbl    = lhbl;
    assign pix.lvbl    = lvbl;

    // write on every clk while selected, per enabled lane
    assign we = ~dsn & {cpu_nbytes{pal_cs}};

    colmix_prio u_prio (
        .clk      (clk),
        .rst_n    (rst_n),
        .gfx_en   (gfx_en),
        .char_pxl (char_pxl),
        .scr1_pxl (scr1_pxl),
        .scr2_pxl (scr2_pxl),
        .obj_pxl  (obj_pxl),
        .pix      (pix.src)
    );

    colmix_palram u_palram (
        .clk      (clk),
        .cpu_addr (cpu_addr),
        .cpu_dout (cpu_dout),
        .we       (we),
        .cpu_din  (cpu_din),
        .pix      (pix.snk),
        .pal      (pal)
    );

    colmix_blank u_blank (
        .clk      (clk),
        .rst_n    (rst_n),
        .video_en (video_en),
        .pal      (pal),
        .pix      (pix.snk),
        .red      (red),
        .green    (green),
        .blue     (blue),
        .lhbl_dly (lhbl_dly),
        .lvbl_dly (lvbl_dly)
    );

    // a char tile win only reaches the first 64 palette entries
    a_char_range: assert property (@(posedge clk) disable iff (!rst_n)
        (u_prio.win == LYR_CHAR && !pix.pal_addr[pal_aw-1])
            |-> (pix.pal_addr[pal_aw-2:char_w-1] == '0));

endmodule

//--- verif/colmix_tb.sv
// testbench for the colour mixer
// seeded filler over the whole palette, then cpu write/read-back and
// pixel cases from the vector file, each held steady before sampling

`timescale 1ns/100ps

module colmix_tb
    import video_pkg::*;
    import cpu_pkg::*;
();

    localparam int hold_pix     = 8;    // pixel periods per case
    localparam int cen_limit    = 8;    // clks to find a pixel slot
    localparam int strobe_limit = 64;   // clks for blanking to follow

    logic                  clk     = 1'b0;
    logic                  pxl_cen = 1'b0;
    logic                  rst_n, video_en, lhbl, lvbl, pal_cs;
    logic [gfx_layers-1:0] gfx_en;
    logic [cpu_aw-1:0]     cpu_addr;
    logic [cpu_dw-1:0]     cpu_dout, cpu_din;
    logic [cpu_nbytes-1:0] dsn;
    logic [char_w-1:0]     char_pxl;
    logic [scr_w-1:0]      scr1_pxl, scr2_pxl;
    logic [obj_w-1:0]      obj_pxl;
    logic [col_w-1:0]      red, green, blue;
    logic                  lhbl_dly, lvbl_dly;

    logic [cpu_dw-1:0] pal_model [2**pal_aw];  // expected palette contents
    int                seed, fd, nf, rnd;
    int                tests, failed, errors, test_errs;
    logic [8*160-1:0]  line;
    logic [7:0]        tag;                     // W or P, # for comments
    logic [15:0]       f_ven, f_gfx, f_hb, f_vb, f_chr, f_s1, f_s2, f_obj;
    logic [15:0]       f_r, f_g, f_b, wa, wl, wd, word;

    always #50 clk = ~clk;                      // 100 ns period

    always @(posedge clk) pxl_cen <= ~pxl_cen;  // high every second clk

    colmix_top dut0 (
        .clk (clk), .rst_n (rst_n), .pxl_cen (pxl_cen), .video_en (video_en),
        .gfx_en (gfx_en), .lhbl (lhbl), .lvbl (lvbl), .pal_cs (pal_cs),
        .cpu_addr (cpu_addr), .cpu_dout (cpu_dout), .dsn (dsn),
        .char_pxl (char_pxl), .scr1_pxl (scr1_pxl), .scr2_pxl (scr2_pxl),
        .obj_pxl (obj_pxl), .cpu_din (cpu_din), .red (red), .green (green),
        .blue (blue), .lhbl_dly (lhbl_dly), .lvbl_dly (lvbl_dly)
    );

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            errors++;
            test_errs++;
        end
    endtask

    // one line per finished test
    task automatic end_test(input string what);
        tests++;
        if (test_errs == 0) begin
            $display("test %0d %s ok", tests, what);
        end else begin
            $display("test %0d %s failed", tests, what);
            failed++;
        end
        test_errs = 0;
    endtask

    task automatic fill_palette;
        logic [cpu_dw-1:0] w;
        for (int a = 0; a < 2**pal_aw; a++) begin
            rnd = $random(seed);
            w   = rnd[cpu_dw-1:0];
            @(posedge clk);
            pal_cs   <= 1'b1;           // back to back, one word per clk
            dsn      <= '0;
            cpu_addr <= a[cpu_aw-1:0];
            cpu_dout <= w;
            pal_model[a] = w;
        end
        @(posedge clk);
        pal_cs <= 1'b0;
        dsn    <= '1;
    endtask

    // byte merge, dsn low enables a lane
    task automatic write_word(input logic [cpu_aw-1:0] addr, input logic [1:0] lanes_n,
                              input logic [cpu_dw-1:0] data);
        @(posedge clk);
        pal_cs   <= 1'b1;
        cpu_addr <= addr;
        cpu_dout <= data;
        dsn      <= lanes_n;
        @(posedge clk);                 // write lands on this edge
        pal_cs <= 1'b0;
        dsn    <= '1;
        if (!lanes_n[0]) pal_model[addr][7:0]  = data[7:0];
        if (!lanes_n[1]) pal_model[addr][15:8] = data[15:8];
    endtask

    task automatic read_back(input logic [cpu_aw-1:0] addr, output logic [cpu_dw-1:0] w);
        @(posedge clk);
        cpu_addr <= addr;
        @(posedge clk);                 // cpu_din registered here
        @(negedge clk);
        w = cpu_din;
    endtask

    // stop on an edge with pxl_cen low, new inputs then sit in a cen-high clk
    task automatic find_pixel_slot;
        int n;
        n = 0;
        @(posedge clk);
        while (pxl_cen !== 1'b0 && n < cen_limit) begin
            @(posedge clk);
            n++;
        end
        if (pxl_cen !== 1'b0) begin
            $display("pixel enable stopped toggling before a case");
            errors++;
            test_errs++;
        end
    endtask

    task automatic follow_strobes;
        int n;
        n = 0;
        @(negedge clk);
        while ((lhbl_dly !== lhbl || lvbl_dly !== lvbl) && n < strobe_limit) begin
            @(negedge clk);
            n++;
        end
        if (lhbl_dly !== lhbl || lvbl_dly !== lvbl) begin
            $display("delayed blanking never followed the blanking inputs");
            errors++;
            test_errs++;
        end
    endtask

    task automatic hold_pixels(input int count);
        int seen;
        int n;
        seen = 0;
        n    = 0;
        while (seen < count && n < 4*count) begin
            @(posedge clk);
            if (pxl_cen === 1'b1) seen++;   // dut sampling edge
            n++;
        end
        if (seen < count) begin
            $display("pixel enable went missing while holding a case");
            errors++;
            test_errs++;
        end
    endtask

    task automatic run_pixel_case;
        find_pixel_slot;
        video_en <= f_ven[0];
        gfx_en   <= f_gfx[gfx_layers-1:0];
        lhbl     <= f_hb[0];
        lvbl     <= f_vb[0];
        char_pxl <= f_chr[char_w-1:0];
        scr1_pxl <= f_s1[scr_w-1:0];
        scr2_pxl <= f_s2[scr_w-1:0];
        obj_pxl  <= f_obj[obj_w-1:0];
        follow_strobes;
        hold_pixels(hold_pix);
        @(negedge clk);                 // outputs settled mid cycle
        check_value("red", 16'(red), f_r);
        check_value("green", 16'(green), f_g);
        check_value("blue", 16'(blue), f_b);
        check_value("lhbl_dly", 16'(lhbl_dly), 16'(f_hb[0]));
        check_value("lvbl_dly", 16'(lvbl_dly), 16'(f_vb[0]));
    endtask

    initial begin
        seed      = 65872;
        tests     = 0;
        failed    = 0;
        errors    = 0;
        test_errs = 0;
        rst_n     = 1'b0;
        video_en  = 1'b0;
        gfx_en    = '1;
        lhbl      = 1'b0;
        lvbl      = 1'b0;
        pal_cs    = 1'b0;
        cpu_addr  = '0;
        cpu_dout  = '0;
        dsn       = '1;                 // no lane enabled
        char_pxl  = '0;
        scr1_pxl  = '0;
        scr2_pxl  = '0;
        obj_pxl   = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("red", 16'(red), 16'h0);
        check_value("green", 16'(green), 16'h0);
        check_value("blue", 16'(blue), 16'h0);
        check_value("lhbl_dly", 16'(lhbl_dly), 16'h0);
        check_value("lvbl_dly", 16'(lvbl_dly), 16'h0);
        end_test("outputs after reset");
        fill_palette;
        fd = $fopen("verif/colmix_vectors.txt", "r");
        if (fd == 0) begin
            $display("vector file verif/colmix_vectors.txt could not be opened");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                nf = $sscanf(line, "%s", tag);
                if (nf < 1 || tag == "#") continue;
                if (tag == "W") begin
                    nf = $sscanf(line, "%s %h %h %h", tag, wa, wl, wd);
                    if (nf != 4) begin
                        $display("cpu vector line has missing fields");
                        errors++;
                        continue;
                    end
                    write_word(wa[cpu_aw-1:0], wl[1:0], wd);
                    read_back(wa[cpu_aw-1:0], word);
                    check_value("cpu_din", word, pal_model[wa[cpu_aw-1:0]]);
                    end_test($sformatf("cpu word %h lanes_n %h", wa[cpu_aw-1:0], wl[1:0]));
                end else if (tag == "P") begin
                    nf = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h", tag, f_ven,
                                 f_gfx, f_hb, f_vb, f_chr, f_s1, f_s2, f_obj, f_r, f_g, f_b);
                    if (nf != 12) begin
                        $display("pixel vector line has missing fields");
                        errors++;
                        continue;
                    end
                    run_pixel_case;
                    end_test($sformatf("pixel gfx %h chr %h s1 %h s2 %h obj %h",
                                       f_gfx, f_chr, f_s1, f_s2, f_obj));
                end else begin
                    $display("vector line of unknown kind %s", tag);
                    errors++;
                end
            end
            $fclose(fd);
        end
        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0 && tests > 1) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- files.f
common/video_pkg.sv
common/cpu_pkg.sv
common/pix_if.sv
colmix/colmix_prio.sv
colmix/colmix_palram.sv
colmix/colmix_blank.sv
verilog/colmix_top.sv
verif/colmix_tb.sv

//--- Makefile
# Verilator flow for the colour mixer testbench

VERILATOR ?= verilator
TOP       ?= colmix_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= PASS: all tests

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- verif/colmix_vectors.txt
# W addr dsn data : cpu write (dsn active low lanes), then read back
# P video_en gfx_en lhbl lvbl char scr1 scr2 obj red green blue, all hex
W 011 0 1234
W 122 0 7F00
W 122 2 AA5A
W 122 1 3C99
W 233 0 4567
W 405 0 7ABC
W 230 0 0F0F
W 300 2 00AB
W 301 1 CD00
# tile opacity order, object transparent
P 1 F 1 1 11 122 233 000 09 06 04
P 1 F 1 1 10 122 233 000 15 0B 18
P 1 F 1 1 10 120 233 000 0E 0C 0B
P 1 F 1 1 10 120 230 000 1E 00 1E
# object priority against tile priority per slot
P 1 F 1 1 11 122 233 C05 19 17 15
P 1 F 1 1 11 122 233 805 09 06 04
P 1 F 1 1 10 122 233 805 19 17 15
P 1 F 1 1 10 522 233 805 15 0B 18
P 1 F 1 1 10 120 233 405 19 17 15
P 1 F 1 1 10 120 233 005 0E 0C 0B
P 1 F 1 1 51 122 233 C05 09 06 04
P 1 F 1 1 10 120 633 405 0E 0C 0B
# layer gating
P 1 E 1 1 11 122 233 000 15 0B 18
P 1 C 1 1 11 122 233 000 0E 0C 0B
P 1 8 1 1 11 122 233 000 1E 00 1E
P 1 7 1 1 11 122 233 C05 09 06 04
P 1 E 1 1 11 122 233 C05 19 17 15
# video enable and blanking
P 0 F 1 1 11 122 233 000 00 00 00
P 1 F 0 1 11 122 233 000 00 00 00
P 1 F 1 0 11 122 233 000 00 00 00
P 1 F 1 1 11 122 233 000 09 06 04
